/* mini_mips.f */
+incdir+logic
logic/mini_mips_pkg.sv
logic/accept_stage.sv
logic/control_unit.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mini_mips.sv
verification/mini_mips_tb.sv

/* Makefile */
# Verilator build and run for mini_mips
VERILATOR ?= verilator
TOP       ?= mini_mips_tb
FILELIST  ?= mini_mips.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/mini_mips_tb.sv */
`timescale 1ns/1ps

`include "mini_mips_defines.svh"

module mini_mips_tb;

  import mini_mips_pkg::*;

  localparam int NUM_ROWS       = 22;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 12 + 50;

  // one instruction, whether it writes, and no idle gap after it
  typedef struct {
    logic [`INST_WIDTH-1:0] word;
    logic                   writes;
    logic                   b2b;
  } row_t;

  typedef struct {
    logic                       wr;
    logic [`REG_ADDR_WIDTH-1:0] rg;
    logic [`DATA_WIDTH-1:0]     data;
  } exp_t;

  logic                       clk = 1'b0;
  logic                       arst_n;
  logic                       instr_req;
  logic [`INST_WIDTH-1:0]     instr;
  logic                       instr_ack;
  logic                       wb_valid;
  logic [`REG_ADDR_WIDTH-1:0] wb_reg;
  logic [`DATA_WIDTH-1:0]     wb_data;

  row_t                   rows [NUM_ROWS];
  logic [`DATA_WIDTH-1:0] model_regs [`NUM_REGS];
  exp_t                   exp_q [$];
  exp_t                   cur;
  logic                   busy     = 1'b0;
  logic                   ack_prev = 1'b0;
  int                     age      = 0;
  int                     checked  = 0;
  int                     cycles   = 0;
  integer                 seed;

  mini_mips mini_mips_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .instr_req (instr_req),
    .instr     (instr),
    .instr_ack (instr_ack),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // helpers

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp));
    end
  endtask

  function automatic logic [`INST_WIDTH-1:0] r_word(
    input logic [`FUNCT_WIDTH-1:0] funct,
    input logic [4:0] rd,
    input logic [4:0] rs,
    input logic [4:0] rt,
    input logic [4:0] shamt
  );
    inst_u u;
    u.r = '{`OP_RTYPE, rs, rt, rd, shamt, funct};
    return u;
  endfunction

  function automatic logic [`INST_WIDTH-1:0] i_word(
    input logic [`OPCODE_WIDTH-1:0] op,
    input logic [4:0] rt,
    input logic [4:0] rs,
    input logic [15:0] imm
  );
    inst_u u;
    u.i = '{op, rs, rt, imm};
    return u;
  endfunction

  // reference model of the register writes
  // immediates are zero-extended and slt compares signed
  task automatic predict_write(
    input  logic [`INST_WIDTH-1:0]     word,
    output logic [`REG_ADDR_WIDTH-1:0] dst,
    output logic [`DATA_WIDTH-1:0]     val
  );
    inst_u                  u;
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
    logic [`DATA_WIDTH-1:0] imm;
    u   = word;
    a   = model_regs[u.r.rs];
    b   = model_regs[u.r.rt];
    imm = {16'b0, u.i.imm};
    dst = u.r.rd;
    val = '0;
    if (u.r.opcode == `OP_RTYPE) begin
      case (u.r.funct)
        `FN_ADD: val = a + b;
        `FN_SUB: val = a - b;
        `FN_AND: val = a & b;
        `FN_OR:  val = a | b;
        `FN_XOR: val = a ^ b;
        `FN_SLT: val = {31'b0, $signed(a) < $signed(b)};
        `FN_SLL: val = b << u.r.shamt;
        default: val = '0;
      endcase
    end else begin
      dst = u.i.rt;
      case (u.i.opcode)
        `OP_ADDI: val = a + imm;
        `OP_ANDI: val = a & imm;
        `OP_ORI:  val = a | imm;
        default:  val = '0;
      endcase
    end
  endtask

  task automatic load_table();
    rows[0]  = '{i_word(`OP_ADDI, 5'd1, 5'd0, 16'h0005), 1'b1, 1'b1};
    rows[1]  = '{i_word(`OP_ADDI, 5'd2, 5'd0, 16'hfff0), 1'b1, 1'b1};
    rows[2]  = '{r_word(`FN_ADD, 5'd3, 5'd1, 5'd2, 5'd0), 1'b1, 1'b0};
    rows[3]  = '{r_word(`FN_SUB, 5'd4, 5'd1, 5'd2, 5'd0), 1'b1, 1'b0};
    rows[4]  = '{r_word(`FN_AND, 5'd5, 5'd3, 5'd2, 5'd0), 1'b1, 1'b0};
    rows[5]  = '{r_word(`FN_OR, 5'd6, 5'd1, 5'd2, 5'd0), 1'b1, 1'b1};
    rows[6]  = '{r_word(`FN_XOR, 5'd7, 5'd3, 5'd1, 5'd0), 1'b1, 1'b0};
    rows[7]  = '{r_word(`FN_SLT, 5'd8, 5'd4, 5'd1, 5'd0), 1'b1, 1'b0};
    rows[8]  = '{r_word(`FN_SLT, 5'd9, 5'd1, 5'd4, 5'd0), 1'b1, 1'b0};
    rows[9]  = '{r_word(`FN_SLL, 5'd10, 5'd0, 5'd1, 5'd28), 1'b1, 1'b0};
    rows[10] = '{i_word(`OP_ANDI, 5'd11, 5'd4, 16'h8015), 1'b1, 1'b0};
    rows[11] = '{i_word(`OP_ORI, 5'd12, 5'd4, 16'ha000), 1'b1, 1'b1};
    // r0 as destination and as source
    rows[12] = '{i_word(`OP_ADDI, 5'd0, 5'd1, 16'h0007), 1'b0, 1'b1};
    rows[13] = '{r_word(`FN_ADD, 5'd13, 5'd0, 5'd1, 5'd0), 1'b1, 1'b0};
    // unknown opcode and unknown funct
    rows[14] = '{i_word(6'h3f, 5'd14, 5'd1, 16'h0001), 1'b0, 1'b0};
    rows[15] = '{r_word(6'h3f, 5'd15, 5'd1, 5'd1, 5'd0), 1'b0, 1'b1};
    rows[16] = '{r_word(`FN_ADD, 5'd15, 5'd15, 5'd1, 5'd0), 1'b1, 1'b0};
    // dependent chain with no idle cycles
    rows[17] = '{i_word(`OP_ADDI, 5'd16, 5'd0, 16'h1234), 1'b1, 1'b1};
    rows[18] = '{r_word(`FN_ADD, 5'd17, 5'd16, 5'd16, 5'd0), 1'b1, 1'b1};
    rows[19] = '{r_word(`FN_SLL, 5'd18, 5'd0, 5'd17, 5'd4), 1'b1, 1'b1};
    rows[20] = '{r_word(`FN_SUB, 5'd19, 5'd18, 5'd16, 5'd0), 1'b1, 1'b1};
    rows[21] = '{r_word(`FN_XOR, 5'd20, 5'd19, 5'd17, 5'd0), 1'b1, 1'b0};
  endtask

  // four-phase handshake for one row
  task automatic send_instr(input int idx);
    exp_t e;
    predict_write(rows[idx].word, e.rg, e.data);
    e.wr = rows[idx].writes;
    if (e.wr) begin
      model_regs[e.rg] = e.data;
    end
    exp_q.push_back(e);
    instr     <= rows[idx].word;
    instr_req <= 1'b1;
    @(posedge clk);
    while (!instr_ack) begin
      @(posedge clk);
    end
    instr_req <= 1'b0;
    @(posedge clk);
    expect_equal(32'(instr_ack), 32'd1, "instr_ack one edge after req fell");
    @(posedge clk);
    expect_equal(32'(instr_ack), 32'd0, "instr_ack two edges after req fell");
  endtask

  //////////////////////////////////////////////////////////////////////
  // writeback monitor
  // values seen here are the ones from before each edge

  always @(posedge clk) begin
    if (arst_n) begin
      // age 2 here means wb_valid was raised by the 2nd edge after ack
      expect_equal(32'(wb_valid), 32'(busy && age == 2 && cur.wr), "wb_valid");
      if (busy && age == 2) begin
        if (cur.wr) begin
          expect_equal(32'(wb_reg), 32'(cur.rg), "wb_reg");
          expect_equal(wb_data, cur.data, "wb_data");
        end
        busy    <= 1'b0;
        checked <= checked + 1;
      end else if (busy) begin
        age <= age + 1;
      end
      if (instr_ack && !ack_prev) begin
        if (exp_q.size() == 0) begin
          abort_run("instr_ack rose with no request outstanding");
        end else begin
          cur  <= exp_q.pop_front();
          busy <= 1'b1;
          age  <= 1;
        end
      end
      ack_prev <= instr_ack;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int gap;
    $timeformat(-9, 0, " ns", 0);
    seed      = 32'h66ce7b6e;
    arst_n    = 1'b0;
    instr_req = 1'b0;
    instr     = '0;
    for (int r = 0; r < `NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    load_table();
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    expect_equal(32'(instr_ack), 32'd0, "instr_ack after reset");
    expect_equal(32'(wb_valid), 32'd0, "wb_valid after reset");
    for (int i = 0; i < NUM_ROWS; i++) begin
      send_instr(i);
      if (!rows[i].b2b) begin
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(posedge clk);
      end
    end
    while (checked != NUM_ROWS) begin
      @(posedge clk);
    end
    // stray writebacks after the last row
    repeat (4) @(posedge clk);
    $display("test passed");
    $finish;
  end

endmodule

/* logic/mini_mips.sv */
`timescale 1ns/1ps

`include "mini_mips_defines.svh"

module mini_mips (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       instr_req,
  input  logic [`INST_WIDTH-1:0]     instr,
  output logic                       instr_ack,
  output logic                       wb_valid,
  output logic [`REG_ADDR_WIDTH-1:0] wb_reg,
  output logic [`DATA_WIDTH-1:0]     wb_data
);

  import mini_mips_pkg::*;

  // accept to decode
  logic  acc_valid;
  inst_u acc_inst;

  // decode to execute
  logic                       dec_valid;
  logic [`ALU_OP_WIDTH-1:0]   dec_alu_op;
  logic                       dec_use_imm;
  logic                       dec_reg_write;
  logic [`REG_ADDR_WIDTH-1:0] dec_dst;
  logic [`REG_ADDR_WIDTH-1:0] dec_rs;
  logic [`REG_ADDR_WIDTH-1:0] dec_rt;
  logic [`DATA_WIDTH-1:0]     dec_a;
  logic [`DATA_WIDTH-1:0]     dec_b;
  logic [`IMM_WIDTH-1:0]      dec_imm;
  logic [`SHAMT_WIDTH-1:0]    dec_shamt;

  accept_stage accept_stage_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .instr_req (instr_req),
    .instr     (instr),
    .instr_ack (instr_ack),
    .acc_valid (acc_valid),
    .acc_inst  (acc_inst)
  );

  // writeback loops back into the register file
  decode_stage decode_stage_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .acc_valid     (acc_valid),
    .acc_inst      (acc_inst),
    .wb_valid      (wb_valid),
    .wb_reg        (wb_reg),
    .wb_data       (wb_data),
    .dec_valid     (dec_valid),
    .dec_alu_op    (dec_alu_op),
    .dec_use_imm   (dec_use_imm),
    .dec_reg_write (dec_reg_write),
    .dec_dst       (dec_dst),
    .dec_rs        (dec_rs),
    .dec_rt        (dec_rt),
    .dec_a         (dec_a),
    .dec_b         (dec_b),
    .dec_imm       (dec_imm),
    .dec_shamt     (dec_shamt)
  );

  execute_stage execute_stage_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .dec_valid     (dec_valid),
    .dec_alu_op    (dec_alu_op),
    .dec_use_imm   (dec_use_imm),
    .dec_reg_write (dec_reg_write),
    .dec_dst       (dec_dst),
    .dec_rs        (dec_rs),
    .dec_rt        (dec_rt),
    .dec_a         (dec_a),
    .dec_b         (dec_b),
    .dec_imm       (dec_imm),
    .dec_shamt     (dec_shamt),
    .wb_valid      (wb_valid),
    .wb_reg        (wb_reg),
    .wb_data       (wb_data)
  );

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps

`include "mini_mips_defines.svh"

module execute_stage (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       dec_valid,
  input  logic [`ALU_OP_WIDTH-1:0]   dec_alu_op,
  input  logic                       dec_use_imm,
  input  logic                       dec_reg_write,
  input  logic [`REG_ADDR_WIDTH-1:0] dec_dst,
  input  logic [`REG_ADDR_WIDTH-1:0] dec_rs,
  input  logic [`REG_ADDR_WIDTH-1:0] dec_rt,
  input  logic [`DATA_WIDTH-1:0]     dec_a,
  input  logic [`DATA_WIDTH-1:0]     dec_b,
  input  logic [`IMM_WIDTH-1:0]      dec_imm,
  input  logic [`SHAMT_WIDTH-1:0]    dec_shamt,
  output logic                       wb_valid,
  output logic [`REG_ADDR_WIDTH-1:0] wb_reg,
  output logic [`DATA_WIDTH-1:0]     wb_data
);

  logic [`DATA_WIDTH-1:0] op_a;
  logic [`DATA_WIDTH-1:0] op_b_fwd;
  logic [`DATA_WIDTH-1:0] op_b;
  logic [`DATA_WIDTH-1:0] imm_ext;
  logic [`DATA_WIDTH-1:0] alu_result;

  //////////////////////////////////////////////////////////////////////
  // forwarding from the writeback register

  // wb_valid is never set for r0, no zero check needed
  assign op_a     = (wb_valid && wb_reg == dec_rs) ? wb_data : dec_a;
  assign op_b_fwd = (wb_valid && wb_reg == dec_rt) ? wb_data : dec_b;

  // immediates are zero-extended
  assign imm_ext = {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, dec_imm};
  assign op_b    = dec_use_imm ? imm_ext : op_b_fwd;

  //////////////////////////////////////////////////////////////////////
  // alu

  always_comb begin
    case (dec_alu_op)
      `ALU_ADD: alu_result = op_a + op_b;
      `ALU_SUB: alu_result = op_a - op_b;
      `ALU_AND: alu_result = op_a & op_b;
      `ALU_OR:  alu_result = op_a | op_b;
      `ALU_XOR: alu_result = op_a ^ op_b;
      `ALU_SLT: begin
        alu_result = {{(`DATA_WIDTH - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      end
      // sll shifts rt by shamt
      `ALU_SLL: alu_result = op_b << dec_shamt;
      default:  alu_result = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // execute register

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= dec_valid && dec_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      wb_reg  <= dec_dst;
      wb_data <= alu_result;
    end
  end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

`include "mini_mips_defines.svh"

module decode_stage (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       acc_valid,
  input  mini_mips_pkg::inst_u       acc_inst,
  input  logic                       wb_valid,
  input  logic [`REG_ADDR_WIDTH-1:0] wb_reg,
  input  logic [`DATA_WIDTH-1:0]     wb_data,
  output logic                       dec_valid,
  output logic [`ALU_OP_WIDTH-1:0]   dec_alu_op,
  output logic                       dec_use_imm,
  output logic                       dec_reg_write,
  output logic [`REG_ADDR_WIDTH-1:0] dec_dst,
  output logic [`REG_ADDR_WIDTH-1:0] dec_rs,
  output logic [`REG_ADDR_WIDTH-1:0] dec_rt,
  output logic [`DATA_WIDTH-1:0]     dec_a,
  output logic [`DATA_WIDTH-1:0]     dec_b,
  output logic [`IMM_WIDTH-1:0]      dec_imm,
  output logic [`SHAMT_WIDTH-1:0]    dec_shamt
);

  logic [`ALU_OP_WIDTH-1:0]   alu_op;
  logic                       use_imm;
  logic                       reg_write;
  logic                       dst_is_rd;
  logic [`REG_ADDR_WIDTH-1:0] dst;
  logic [`DATA_WIDTH-1:0]     rd_data_a;
  logic [`DATA_WIDTH-1:0]     rd_data_b;

  control_unit control_unit_i (
    .inst      (acc_inst),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .reg_write (reg_write),
    .dst_is_rd (dst_is_rd)
  );

  register_file register_file_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_addr_a (acc_inst.r.rs),
    .rd_addr_b (acc_inst.r.rt),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wb_valid),
    .wr_addr   (wb_reg),
    .wr_data   (wb_data)
  );

  assign dst = dst_is_rd ? acc_inst.r.rd : acc_inst.i.rt;

  //////////////////////////////////////////////////////////////////////
  // decode register

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid     <= 1'b0;
      dec_reg_write <= 1'b0;
    end else begin
      dec_valid <= acc_valid;
      if (acc_valid) begin
        // writes to r0 are dropped here
        dec_reg_write <= reg_write && (dst != '0);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid) begin
      dec_alu_op  <= alu_op;
      dec_use_imm <= use_imm;
      dec_dst     <= dst;
      dec_rs      <= acc_inst.r.rs;
      dec_rt      <= acc_inst.r.rt;
      dec_a       <= rd_data_a;
      dec_b       <= rd_data_b;
      dec_imm     <= acc_inst.i.imm;
      dec_shamt   <= acc_inst.r.shamt;
    end
  end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

`include "mini_mips_defines.svh"

module register_file (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [`REG_ADDR_WIDTH-1:0] rd_addr_a,
  input  logic [`REG_ADDR_WIDTH-1:0] rd_addr_b,
  output logic [`DATA_WIDTH-1:0]     rd_data_a,
  output logic [`DATA_WIDTH-1:0]     rd_data_b,
  input  logic                       wr_en,
  input  logic [`REG_ADDR_WIDTH-1:0] wr_addr,
  input  logic [`DATA_WIDTH-1:0]     wr_data
);

  logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

  // r0 is hardwired, write-through for same-cycle reads
  function automatic logic [`DATA_WIDTH-1:0] read_port(
    input logic [`REG_ADDR_WIDTH-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end else if (wr_en && wr_addr == addr) begin
      return wr_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rd_data_a = read_port(rd_addr_a);
    rd_data_b = read_port(rd_addr_b);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

endmodule

/* logic/control_unit.sv */
`timescale 1ns/1ps

`include "mini_mips_defines.svh"

module control_unit (
  input  mini_mips_pkg::inst_u     inst,
  output logic [`ALU_OP_WIDTH-1:0] alu_op,
  output logic                     use_imm,
  output logic                     reg_write,
  output logic                     dst_is_rd
);

  always_comb begin
    alu_op    = `ALU_ADD;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    dst_is_rd = 1'b0;
    case (inst.i.opcode)
      `OP_RTYPE: begin
        dst_is_rd = 1'b1;
        reg_write = 1'b1;
        case (inst.r.funct)
          `FN_ADD: alu_op = `ALU_ADD;
          `FN_SUB: alu_op = `ALU_SUB;
          `FN_AND: alu_op = `ALU_AND;
          `FN_OR:  alu_op = `ALU_OR;
          `FN_XOR: alu_op = `ALU_XOR;
          `FN_SLT: alu_op = `ALU_SLT;
          `FN_SLL: alu_op = `ALU_SLL;
          // unknown funct becomes a no-op
          default: reg_write = 1'b0;
        endcase
      end
      `OP_ADDI, `OP_ANDI, `OP_ORI: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
        if (inst.i.opcode == `OP_ANDI) begin
          alu_op = `ALU_AND;
        end else if (inst.i.opcode == `OP_ORI) begin
          alu_op = `ALU_OR;
        end
      end
      default: begin
        reg_write = 1'b0;
      end
    endcase
  end

endmodule

/* logic/accept_stage.sv */
`timescale 1ns/1ps

`include "mini_mips_defines.svh"

module accept_stage (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   instr_req,
  input  logic [`INST_WIDTH-1:0] instr,
  output logic                   instr_ack,
  output logic                   acc_valid,
  output mini_mips_pkg::inst_u   acc_inst
);

  logic capture;

  // new request only while ack is low
  assign capture = instr_req && !instr_ack;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instr_ack <= 1'b0;
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= capture;
      if (capture) begin
        instr_ack <= 1'b1;
      end else if (!instr_req) begin
        instr_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      acc_inst <= instr;
    end
  end

endmodule

/* logic/mini_mips_pkg.sv */
`include "mini_mips_defines.svh"

package mini_mips_pkg;

  // r-type layout
  typedef struct packed {
    logic [`OPCODE_WIDTH-1:0]   opcode;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`SHAMT_WIDTH-1:0]    shamt;
    logic [`FUNCT_WIDTH-1:0]    funct;
  } r_fields_t;

  // i-type layout
  typedef struct packed {
    logic [`OPCODE_WIDTH-1:0]   opcode;
    logic [`REG_ADDR_WIDTH-1:0] rs;
    logic [`REG_ADDR_WIDTH-1:0] rt;
    logic [`IMM_WIDTH-1:0]      imm;
  } i_fields_t;

  // same word, two views
  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } inst_u;

endpackage

/* logic/mini_mips_defines.svh */
`ifndef MINI_MIPS_DEFINES_SVH
`define MINI_MIPS_DEFINES_SVH

// datapath widths
`define DATA_WIDTH     32
`define INST_WIDTH     32
`define NUM_REGS       32
`define REG_ADDR_WIDTH 5
`define IMM_WIDTH      16
`define SHAMT_WIDTH    5
`define OPCODE_WIDTH   6
`define FUNCT_WIDTH    6
`define ALU_OP_WIDTH   4

// opcodes
`define OP_RTYPE 6'd0
`define OP_ADDI  6'd8
`define OP_ANDI  6'd12
`define OP_ORI   6'd13

// r-type function codes, mips encoding
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_XOR 6'h26
`define FN_SLT 6'h2a
`define FN_SLL 6'h00

// alu operations
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_OR  4'd3
`define ALU_XOR 4'd4
`define ALU_SLT 4'd5
`define ALU_SLL 4'd6

`endif
